// File: hdl/board_pkg.sv
package board_pkg;

	// ####################################################################
	// spi master configuration
	// ####################################################################

	// width of the sclk divider field
	localparam int SPI_DIV_W = 8;

	// chip selects on this board, one per spi port
	localparam int SPI_NUM_CS = 2;

	// settings handed from the register block to the spi master
	// sclk half period is div + 1 sys_clk cycles
	typedef struct packed {
		logic [SPI_DIV_W-1:0] div;
		logic                 cs_sel;
		logic                 cs_hold;
	} spi_cfg_t;

	// fastest clock, first chip select, no hold
	localparam spi_cfg_t SPI_CFG_RST = '{
		div:     '0,
		cs_sel:  1'b0,
		cs_hold: 1'b0
	};

	// ####################################################################
	// spi master sequencing
	// ####################################################################

	// sclk_low and sclk_high each last div + 1 cycles per bit
	typedef enum logic [1:0] {
		idle      = 2'd0,
		sclk_low  = 2'd1,
		sclk_high = 2'd2
	} spi_state_e;

endpackage

// File: hdl/dbg_pkg.sv
package dbg_pkg;

	// one debugger access, qualified by dbg_req
	typedef struct packed {
		logic [1:0]  addr;
		logic [31:0] wdata;
		logic        wr_en;
	} dbg_req_t;

	// word addresses of the debug register block
	typedef enum logic [1:0] {
		reg_ctrl   = 2'd0,
		reg_txdata = 2'd1,
		reg_rxdata = 2'd2,
		reg_status = 2'd3
	} dbg_reg_e;

	// ####################################################################
	// register field positions
	// ####################################################################

	// reg_ctrl, div sits in the low byte
	localparam int CTRL_CS_SEL_BIT  = 8;
	localparam int CTRL_CS_HOLD_BIT = 9;

	// reg_status
	localparam int STAT_BUSY_BIT = 0;
	localparam int STAT_RUN_BIT  = 1;

endpackage

// File: hdl/dbg_regs.sv
module dbg_regs (
	input  logic                sys_clk,
	input  logic                rst_n,
	input  logic                dbg_req,
	input  dbg_pkg::dbg_req_t   dbg_in,
	output logic                dbg_ack,
	output logic [31:0]         dbg_dout,
	input  logic                busy,
	input  logic [7:0]          rx_byte,
	input  logic                running,
	output board_pkg::spi_cfg_t cfg,
	output logic                start,
	output logic [7:0]          tx_byte
);
	import board_pkg::*;
	import dbg_pkg::*;

	logic        access;
	dbg_reg_e    reg_addr;
	logic        wr_ctrl;
	logic        wr_tx;
	logic [31:0] rd_data;

	// ####################################################################
	// request decode
	// ####################################################################

	// a request counts as new unless it is being acknowledged right now,
	// so a held req yields one ack every other cycle
	assign access   = dbg_req & ~dbg_ack;
	assign reg_addr = dbg_reg_e'(dbg_in.addr);
	assign wr_ctrl  = access & dbg_in.wr_en & (reg_addr == reg_ctrl);

	// never restart the engine in the middle of a byte
	assign wr_tx = access & dbg_in.wr_en & (reg_addr == reg_txdata) & ~busy;

	// read mux, unused bits read as zero
	always_comb begin
		rd_data = '0;
		case (reg_addr)
			reg_ctrl: begin
				rd_data[SPI_DIV_W-1:0]   = cfg.div;
				rd_data[CTRL_CS_SEL_BIT]  = cfg.cs_sel;
				rd_data[CTRL_CS_HOLD_BIT] = cfg.cs_hold;
			end
			reg_rxdata: begin
				rd_data[7:0] = rx_byte;
			end
			reg_status: begin
				rd_data[STAT_BUSY_BIT] = busy;
				rd_data[STAT_RUN_BIT]  = running;
			end
			default: begin
				// txdata is write only
				rd_data = '0;
			end
		endcase
	end

	// ####################################################################
	// handshake and control register
	// ####################################################################

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			dbg_ack <= 1'b0;
			start   <= 1'b0;
			cfg     <= SPI_CFG_RST;
		end else begin
			dbg_ack <= access;
			// lines up with the ack of the accepted write
			start <= wr_tx;
			if (wr_ctrl) begin
				cfg.div     <= dbg_in.wdata[SPI_DIV_W-1:0];
				cfg.cs_sel  <= dbg_in.wdata[CTRL_CS_SEL_BIT];
				cfg.cs_hold <= dbg_in.wdata[CTRL_CS_HOLD_BIT];
			end
		end
	end

	// read data and tx byte, valid in the ack cycle
	always_ff @(posedge sys_clk) begin
		if (access)
			dbg_dout <= rd_data;
		if (wr_tx)
			tx_byte <= dbg_in.wdata[7:0];
	end

endmodule

// File: hdl/spi_master.sv
module spi_master #(
	parameter int spi_num_cs = board_pkg::SPI_NUM_CS
) (
	input  logic                  sys_clk,
	input  logic                  rst_n,
	input  board_pkg::spi_cfg_t   cfg,
	input  logic                  start,
	input  logic [7:0]            tx_byte,
	output logic                  busy,
	output logic [7:0]            rx_byte,
	output logic                  sclk,
	output logic                  mosi,
	input  logic                  miso,
	output logic [spi_num_cs-1:0] ncs
);
	import board_pkg::*;

	spi_state_e           state;
	logic [SPI_DIV_W-1:0] div_cnt;
	logic [2:0]           bit_cnt;
	logic                 phase_done;
	logic                 last_bit;
	spi_cfg_t             cfg_q;
	spi_cfg_t             cs_cfg;
	logic [7:0]           tx_shift;
	logic [7:0]           rx_shift;

	// one half period of sclk has elapsed
	assign phase_done = (div_cnt == cfg_q.div);
	assign last_bit   = (bit_cnt == 3'd7);

	// ####################################################################
	// bit sequencer, mode 0, msb first
	// ####################################################################

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			state   <= idle;
			div_cnt <= '0;
			bit_cnt <= '0;
			busy    <= 1'b0;
			sclk    <= 1'b0;
			mosi    <= 1'b0;
			rx_byte <= '0;
		end else begin
			case (state)
				idle: begin
					if (start) begin
						state   <= sclk_low;
						div_cnt <= '0;
						bit_cnt <= '0;
						busy    <= 1'b1;
						// first bit set up ahead of the first rising edge
						mosi <= tx_byte[7];
					end
				end
				sclk_low: begin
					if (phase_done) begin
						state   <= sclk_high;
						div_cnt <= '0;
						sclk    <= 1'b1;
					end else begin
						div_cnt <= div_cnt + 1'b1;
					end
				end
				sclk_high: begin
					if (phase_done) begin
						div_cnt <= '0;
						sclk    <= 1'b0;
						if (last_bit) begin
							state   <= idle;
							busy    <= 1'b0;
							mosi    <= 1'b0;
							rx_byte <= rx_shift;
						end else begin
							state   <= sclk_low;
							bit_cnt <= bit_cnt + 1'b1;
							// next bit leaves on the falling edge
							mosi <= tx_shift[6];
						end
					end else begin
						div_cnt <= div_cnt + 1'b1;
					end
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	// shift registers and the settings of the running transfer
	always_ff @(posedge sys_clk) begin
		if (state == idle && start) begin
			cfg_q    <= cfg;
			tx_shift <= tx_byte;
		end
		// sample miso as sclk rises
		if (state == sclk_low && phase_done)
			rx_shift <= {rx_shift[6:0], miso};
		if (state == sclk_high && phase_done && !last_bit)
			tx_shift <= {tx_shift[6:0], 1'b0};
	end

	// ####################################################################
	// chip selects
	// ####################################################################

	// a transfer keeps the settings it started with, between transfers
	// the live register decides whether a select is held
	assign cs_cfg = busy ? cfg_q : cfg;

	always_comb begin
		ncs = '1;
		for (int i = 0; i < spi_num_cs; i++) begin
			if ((busy || cs_cfg.cs_hold) && (i == int'(cs_cfg.cs_sel)))
				ncs[i] = 1'b0;
		end
	end

endmodule

// File: hdl/run_indicator.sv
module run_indicator #(
	parameter int window_log2 = 20
) (
	input  logic sys_clk,
	input  logic rst_n,
	input  logic core_running,
	output logic running
);

	logic [window_log2-1:0] win_cnt;
	logic                   seen;
	logic                   win_end;

	// last cycle of the current window
	assign win_end = &win_cnt;

	// ####################################################################
	// activity window
	// ####################################################################

	// any activity inside a window, even one cycle of a single step,
	// keeps the led on for the whole following window
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			win_cnt <= '0;
			seen    <= 1'b0;
			running <= 1'b0;
		end else begin
			win_cnt <= win_cnt + 1'b1;
			if (win_end) begin
				// include activity in the closing cycle itself
				running <= seen | core_running;
				seen    <= 1'b0;
			end else if (core_running) begin
				seen <= 1'b1;
			end
		end
	end

endmodule

// File: hdl/board_top.sv
module board_top #(
	parameter int spi_num_cs  = board_pkg::SPI_NUM_CS,
	parameter int window_log2 = 20
) (
	input  logic                  sys_clk,
	input  logic                  rst_n,
	// debugger access
	input  logic                  dbg_req,
	input  dbg_pkg::dbg_req_t     dbg_in,
	output logic                  dbg_ack,
	output logic [31:0]           dbg_dout,
	// core activity and leds
	input  logic                  core_running,
	output logic                  running,
	output logic                  spi_cs0_active,
	output logic                  spi_cs1_active,
	// spi chip selects, shared by both ports
	output logic [spi_num_cs-1:0] spi_ncs,
	// spi port 1
	output logic                  spi_clk1,
	output logic                  spi_mosi1,
	input  logic                  spi_miso1,
	// spi port 2
	output logic                  spi_clk2,
	output logic                  spi_mosi2,
	input  logic                  spi_miso2
);
	import board_pkg::*;

	spi_cfg_t   cfg;
	logic       start;
	logic [7:0] tx_byte;
	logic       busy;
	logic [7:0] rx_byte;
	logic       spi_sclk;
	logic       spi_mosi;
	logic       spi_miso;

	// ####################################################################
	// spi pin fan-out
	// ####################################################################

	// both ports run off the one engine, a deselected slave drives 0
	assign spi_clk1  = spi_sclk;
	assign spi_mosi1 = spi_mosi;
	assign spi_clk2  = spi_sclk;
	assign spi_mosi2 = spi_mosi;
	assign spi_miso  = spi_miso1 | spi_miso2;

	// led on while its slave is selected
	assign spi_cs0_active = ~spi_ncs[0];
	assign spi_cs1_active = ~spi_ncs[1];

	dbg_regs dbg_regs_i (
		.sys_clk  (sys_clk),
		.rst_n    (rst_n),
		.dbg_req  (dbg_req),
		.dbg_in   (dbg_in),
		.dbg_ack  (dbg_ack),
		.dbg_dout (dbg_dout),
		.busy     (busy),
		.rx_byte  (rx_byte),
		.running  (running),
		.cfg      (cfg),
		.start    (start),
		.tx_byte  (tx_byte)
	);

	spi_master #(
		.spi_num_cs (spi_num_cs)
	) spi_master_i (
		.sys_clk (sys_clk),
		.rst_n   (rst_n),
		.cfg     (cfg),
		.start   (start),
		.tx_byte (tx_byte),
		.busy    (busy),
		.rx_byte (rx_byte),
		.sclk    (spi_sclk),
		.mosi    (spi_mosi),
		.miso    (spi_miso),
		.ncs     (spi_ncs)
	);

	run_indicator #(
		.window_log2 (window_log2)
	) run_indicator_i (
		.sys_clk      (sys_clk),
		.rst_n        (rst_n),
		.core_running (core_running),
		.running      (running)
	);

endmodule

// File: verif/board_top_checker.sv
module board_top_checker #(
	parameter int spi_num_cs = board_pkg::SPI_NUM_CS
) (
	input logic                  sys_clk,
	input logic                  rst_n,
	input logic                  dbg_req,
	input logic                  dbg_ack,
	input logic [spi_num_cs-1:0] spi_ncs,
	input logic                  sclk,
	input logic                  busy
);

	// ####################################################################
	// debug handshake and spi pins
	// ####################################################################

	// a new request gets one ack cycle, one cycle later
	ack_pulse: assert property (@(posedge sys_clk) disable iff (!rst_n)
		$rose(dbg_req) |=> dbg_ack ##1 !dbg_ack)
		else $error("dbg_ack missing, late or longer than one cycle after a request");

	// never two slaves selected at once
	cs_onehot: assert property (@(posedge sys_clk) disable iff (!rst_n)
		$onehot0(~spi_ncs))
		else $error("more than one chip select is low");

	// mode 0 idles with sclk low
	sclk_idle: assert property (@(posedge sys_clk) disable iff (!rst_n)
		!busy |-> !sclk)
		else $error("sclk high while the SPI master is idle");

endmodule

bind board_top board_top_checker #(
	.spi_num_cs (spi_num_cs)
) board_top_checker_i (
	.sys_clk (sys_clk),
	.rst_n   (rst_n),
	.dbg_req (dbg_req),
	.dbg_ack (dbg_ack),
	.spi_ncs (spi_ncs),
	.sclk    (spi_sclk),
	.busy    (busy)
);

// File: verif/board_top_tb.sv
module board_top_tb;
	import dbg_pkg::*;

	localparam int WIN_LOG2    = 6;
	localparam int WIN_LEN     = 1 << WIN_LOG2;
	localparam int RST_CYCLES  = 8;
	localparam int N_REG       = 12;
	localparam int N_XFER      = 16;
	localparam int N_BUSY      = 4;
	localparam int N_WIN       = 10;
	localparam int ACK_LIMIT   = 8;
	localparam int POLL_LIMIT  = 64;
	// slowest byte at div 3 plus the bus accesses around it
	localparam int XFER_CYCLES = 16 * 4 + 32;
	localparam int TIMEOUT_CYCLES = 2 * (XFER_CYCLES * (N_XFER + N_BUSY) +
		(N_WIN + 1) * WIN_LEN + N_REG * 20 + RST_CYCLES);

	logic        sys_clk;
	logic        rst_n;
	logic        dbg_req;
	dbg_req_t    dbg_in;
	logic        dbg_ack;
	logic [31:0] dbg_dout;
	logic        core_running;
	logic        running;
	logic [1:0]  spi_ncs;
	logic        spi_cs0_active;
	logic        spi_cs1_active;
	logic        spi_clk1;
	logic        spi_mosi1;
	logic        spi_miso1;
	logic        spi_clk2;
	logic        spi_mosi2;
	logic        spi_miso2;

	logic [31:0] lcg_state;
	int          checks;
	int          errors;
	logic [7:0]  slave_tx [2];
	logic [7:0]  slave_rx [2];
	int unsigned slave_bits [2];
	logic        sclk_q [2];
	logic [1:0]  port_clk;
	logic [1:0]  port_mosi;
	logic        xfer_sel;
	logic [31:0] exp_ctrl;
	logic [7:0]  exp_rx;
	logic        exp_running;
	logic        run_before;
	logic        run_at_ack;
	logic        win_closed;
	logic        win_act;
	int          win_pos;
	bit [N_WIN*WIN_LEN-1:0] run_pattern;
	bit          pattern_done;

	board_top #(
		.window_log2 (WIN_LOG2)
	) board_top_i (
		.sys_clk        (sys_clk),
		.rst_n          (rst_n),
		.dbg_req        (dbg_req),
		.dbg_in         (dbg_in),
		.dbg_ack        (dbg_ack),
		.dbg_dout       (dbg_dout),
		.core_running   (core_running),
		.running        (running),
		.spi_cs0_active (spi_cs0_active),
		.spi_cs1_active (spi_cs1_active),
		.spi_ncs        (spi_ncs),
		.spi_clk1       (spi_clk1),
		.spi_mosi1      (spi_mosi1),
		.spi_miso1      (spi_miso1),
		.spi_clk2       (spi_clk2),
		.spi_mosi2      (spi_mosi2),
		.spi_miso2      (spi_miso2)
	);

	always #2 sys_clk = ~sys_clk;

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return {8'd0, lcg_state[31:8]};
	endfunction

	// expected chip selects, active low
	function automatic logic [1:0] ncs_for(input logic sel, input logic active);
		logic [1:0] ncs;
		ncs = 2'b11;
		if (active)
			ncs[sel] = 1'b0;
		return ncs;
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED %s at %0t: expected %0h, actual %0h",
				name, $time, expected, actual);
		end
	endtask

	// ####################################################################
	// debug bus and transfer sequences
	// ####################################################################

	task automatic bus_access(input dbg_reg_e reg_addr, input logic [31:0] wdata,
		input logic wr, output logic [31:0] rdata);
		int waited;
		waited = 0;
		@(posedge sys_clk);
		dbg_req <= 1'b1;
		dbg_in  <= '{addr: reg_addr, wdata: wdata, wr_en: wr};
		@(negedge sys_clk);
		while (!dbg_ack && waited < ACK_LIMIT) begin
			@(negedge sys_clk);
			waited++;
		end
		if (!dbg_ack) begin
			errors++;
			$display("ERROR: no dbg_ack within %0d cycles of a request to register %0d",
				ACK_LIMIT, reg_addr);
		end
		rdata      = dbg_dout;
		run_at_ack = run_before;
		@(posedge sys_clk);
		dbg_req <= 1'b0;
	endtask

	task automatic wait_idle();
		logic [31:0] rd;
		int          polls;
		polls = 0;
		bus_access(reg_status, '0, 1'b0, rd);
		while (rd[STAT_BUSY_BIT] && polls < POLL_LIMIT) begin
			bus_access(reg_status, '0, 1'b0, rd);
			polls++;
		end
		if (rd[STAT_BUSY_BIT]) begin
			errors++;
			$display("ERROR: SPI master still busy after %0d status polls", polls);
		end
	endtask

	task automatic do_transfer(input logic [7:0] div, input logic sel, input logic hold,
		input logic [7:0] tx, input logic poke_busy);
		string       name;
		logic [31:0] rd;
		logic [31:0] r;
		int unsigned bits_before;
		name     = poke_busy ? "busy_ignore" : "spi_xfer";
		exp_ctrl = {22'd0, hold, sel, div};
		bus_access(reg_ctrl, exp_ctrl, 1'b1, rd);
		r = next_random();
		@(posedge sys_clk);
		slave_tx[0] <= r[7:0];
		slave_tx[1] <= r[15:8];
		xfer_sel    = sel;
		bits_before = slave_bits[sel];
		bus_access(reg_txdata, {24'd0, tx}, 1'b1, rd);
		if (poke_busy) begin
			bus_access(reg_status, '0, 1'b0, rd);
			check(name, 32'd1, {31'd0, rd[STAT_BUSY_BIT]});
			bus_access(reg_txdata, {24'd0, ~tx}, 1'b1, rd);
		end
		wait_idle();
		exp_rx = sel ? r[15:8] : r[7:0];
		check(name, {24'd0, tx}, {24'd0, slave_rx[sel]});
		check(name, 32'd8, slave_bits[sel] - bits_before);
		bus_access(reg_rxdata, '0, 1'b0, rd);
		check(name, {24'd0, exp_rx}, rd);
		// select released or held once the byte is done
		@(negedge sys_clk);
		check("cs_select", {30'd0, ncs_for(sel, hold)}, {30'd0, spi_ncs});
	endtask

	// ####################################################################
	// spi slaves, one per port
	// ####################################################################

	assign port_clk  = {spi_clk2, spi_clk1};
	assign port_mosi = {spi_mosi2, spi_mosi1};

	// a deselected slave drives 0, msb goes out first
	assign spi_miso1 = ~spi_ncs[0] & slave_tx[0][3'd7 - slave_bits[0][2:0]];
	assign spi_miso2 = ~spi_ncs[1] & slave_tx[1][3'd7 - slave_bits[1][2:0]];

	always @(posedge sys_clk) begin
		for (int i = 0; i < 2; i++) begin
			sclk_q[i] <= port_clk[i];
			if (port_clk[i] && !sclk_q[i] && !spi_ncs[i]) begin
				slave_rx[i]   <= {slave_rx[i][6:0], port_mosi[i]};
				slave_bits[i] <= slave_bits[i] + 1;
			end
		end
		// only the chosen select may be low while sclk runs
		if (spi_clk1 && !sclk_q[0]) begin
			check("cs_select", {30'd0, ncs_for(xfer_sel, 1'b1)}, {30'd0, spi_ncs});
			check("cs_select", {30'd0, ~ncs_for(xfer_sel, 1'b1)},
				{30'd0, spi_cs1_active, spi_cs0_active});
		end
	end

	// ####################################################################
	// activity window model
	// ####################################################################

	always @(posedge sys_clk) begin
		run_before = exp_running;
		win_closed = 1'b0;
		if (!rst_n) begin
			win_pos     = 0;
			win_act     = 1'b0;
			exp_running = 1'b0;
		end else begin
			win_act = win_act | core_running;
			win_pos++;
			if (win_pos == WIN_LEN) begin
				exp_running = win_act;
				win_act     = 1'b0;
				win_pos     = 0;
				win_closed  = 1'b1;
			end
		end
	end

	always @(negedge sys_clk) begin
		if (win_closed && rst_n)
			check("run_window", {31'd0, exp_running}, {31'd0, running});
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge sys_clk);
		$display("ERROR: watchdog expired after %0d cycles, the tests did not finish",
			TIMEOUT_CYCLES);
		$display("Verification failed");
		$finish;
	end

	initial begin
		logic [31:0] r;
		logic [31:0] rd;
		int          kind;
		int          pos;
		sys_clk      = 1'b0;
		rst_n        = 1'b0;
		dbg_req      = 1'b0;
		dbg_in       = '0;
		core_running = 1'b0;
		lcg_state    = 32'h59fb_73c1;
		checks       = 0;
		errors       = 0;
		for (int i = 0; i < 2; i++) begin
			slave_tx[i]   = '0;
			slave_rx[i]   = '0;
			slave_bits[i] = 0;
			sclk_q[i]     = 1'b0;
		end
		xfer_sel     = 1'b0;
		exp_ctrl     = '0;
		exp_rx       = '0;
		exp_running  = 1'b0;
		run_before   = 1'b0;
		win_closed   = 1'b0;
		pattern_done = 1'b0;
		repeat (RST_CYCLES) @(posedge sys_clk);
		rst_n <= 1'b1;

		// control fields read back, rx and status ignore writes
		for (int n = 0; n < N_REG; n++) begin
			r = next_random();
			bus_access(reg_ctrl, r, 1'b1, rd);
			exp_ctrl = {22'd0, r[9:0]};
			bus_access(reg_ctrl, '0, 1'b0, rd);
			check("reg_rw", exp_ctrl, rd);
			bus_access(reg_rxdata, next_random(), 1'b1, rd);
			bus_access(reg_rxdata, '0, 1'b0, rd);
			check("reg_rw", {24'd0, exp_rx}, rd);
			bus_access(reg_status, next_random(), 1'b1, rd);
			bus_access(reg_status, '0, 1'b0, rd);
			check("reg_rw", {30'd0, run_at_ack, 1'b0}, rd);
		end

		for (int n = 0; n < N_XFER; n++) begin
			r = next_random();
			do_transfer({6'd0, r[1:0]}, r[2], r[3], r[11:4], 1'b0);
		end
		for (int n = 0; n < N_BUSY; n++) begin
			r = next_random();
			do_transfer({6'd0, r[1:0]}, r[2], r[3], r[11:4], 1'b1);
		end

		// quiet, single pulse, sparse and dense windows
		for (int w = 0; w < N_WIN; w++) begin
			kind = next_random() % 4;
			pos  = next_random() % WIN_LEN;
			for (int c = 0; c < WIN_LEN; c++) begin
				r = next_random();
				case (kind)
					0: run_pattern[w*WIN_LEN+c] = 1'b0;
					1: run_pattern[w*WIN_LEN+c] = (c == pos);
					2: run_pattern[w*WIN_LEN+c] = (r[7:0] < 8'd12);
					default: run_pattern[w*WIN_LEN+c] = r[0];
				endcase
			end
		end
		fork
			begin
				for (int c = 0; c < N_WIN * WIN_LEN; c++) begin
					@(posedge sys_clk);
					core_running <= run_pattern[c];
				end
				@(posedge sys_clk);
				core_running <= 1'b0;
				pattern_done = 1'b1;
			end
			begin
				while (!pattern_done) begin
					bus_access(reg_status, '0, 1'b0, rd);
					check("run_window", {30'd0, run_at_ack, 1'b0}, rd);
				end
			end
		join
		repeat (WIN_LEN) @(posedge sys_clk);

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// File: filelist.f
hdl/board_pkg.sv
hdl/dbg_pkg.sv
hdl/dbg_regs.sv
hdl/spi_master.sv
hdl/run_indicator.sv
hdl/board_top.sv
verif/board_top_checker.sv
verif/board_top_tb.sv

// File: Bender.yml
package:
  name: board_support

sources:
  - files:
      - hdl/board_pkg.sv
      - hdl/dbg_pkg.sv
      - hdl/dbg_regs.sv
      - hdl/spi_master.sv
      - hdl/run_indicator.sv
      - hdl/board_top.sv
  - target: test
    files:
      - verif/board_top_checker.sv
      - verif/board_top_tb.sv
